//--- lsu_cfg.svh
// Width and depth settings for the load/store unit, included by every file that sizes a signal.
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Data and address width, one word.
`define LSU_XLEN 32

// ROB tag width.
`define LSU_ROB_W 6

// Default queue depths, powers of two.
`define LSU_SQ_DEPTH 4
`define LSU_PEND_DEPTH 4

`endif

//--- lsu_op_pkg.sv
// Load/store opcode encoding with decode helpers, imported by every block that looks at an op.
`include "lsu_cfg.svh"

package lsu_op_pkg;

    // Bit 3 marks a store, bit 2 zero extension, bits 1:0 the log2 of the size.
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } lsu_op_e;

    function automatic logic op_is_store(lsu_op_e op);
        return op[3];
    endfunction

    // Byte lanes touched by op at byte offset off.
    function automatic logic [`LSU_XLEN/8-1:0] op_be(lsu_op_e op, logic [1:0] off);
        logic [`LSU_XLEN/8-1:0] base;
        case (op[1:0])
            2'b00:   base = 'b0001;
            2'b01:   base = 'b0011;
            default: base = 'b1111;
        endcase
        return base << off;
    endfunction

endpackage

//--- lsu_resp_pkg.sv
// Result-side types of the load/store unit: exception causes and pending-entry kinds.
package lsu_resp_pkg;

    // Cause codes as reported on the writeback port.
    typedef enum logic [4:0] {
        NONE        = 5'd0,
        LD_MISALIGN = 5'd4,
        LD_FAULT    = 5'd5,
        ST_MISALIGN = 5'd6
    } lsu_ecause_e;

    typedef enum logic {
        PEND_DONE = 1'b0,  // Result known at push.
        PEND_MEM  = 1'b1   // Waits for a cache response.
    } pend_kind_e;

endpackage

//--- lsu_agu.sv
// Address generation stage: registers one request, forms the address and flags misalignment.
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_agu
    import lsu_op_pkg::*;
    import lsu_resp_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  lsu_op_e               req_op_i,
    input  logic [`LSU_XLEN-1:0]  req_base_i,
    input  logic [`LSU_XLEN-1:0]  req_offset_i,
    input  logic [`LSU_XLEN-1:0]  req_data_i,
    input  logic [`LSU_ROB_W-1:0] req_rob_tag_i,
    output logic                  agu_valid_o,
    input  logic                  agu_ready_i,
    output lsu_op_e               agu_op_o,
    output logic [`LSU_XLEN-1:0]  agu_addr_o,
    output logic [`LSU_XLEN-1:0]  agu_data_o,
    output logic [`LSU_ROB_W-1:0] agu_rob_tag_o,
    output logic                  agu_exc_o,
    output lsu_ecause_e           agu_cause_o
);

    logic                  full_q;
    lsu_op_e               op_q;
    logic [`LSU_XLEN-1:0]  addr_q;
    logic [`LSU_XLEN-1:0]  data_q;
    logic [`LSU_ROB_W-1:0] tag_q;
    logic                  misalign;

    assign req_ready_o = !full_q || agu_ready_i;  // Refills in the cycle it empties.

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (req_ready_o) begin
            full_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            op_q   <= req_op_i;
            addr_q <= req_base_i + req_offset_i;
            data_q <= req_data_i;
            tag_q  <= req_rob_tag_i;
        end
    end

    always_comb begin
        case (op_q[1:0])
            2'b01:   misalign = addr_q[0];     // Halfword at an odd address.
            2'b10:   misalign = |addr_q[1:0];  // Word off a 4-byte boundary.
            default: misalign = 1'b0;
        endcase
    end

    assign agu_valid_o   = full_q;
    assign agu_op_o      = op_q;
    assign agu_addr_o    = addr_q;
    assign agu_data_o    = data_q;
    assign agu_rob_tag_o = tag_q;
    assign agu_exc_o     = misalign;
    assign agu_cause_o   = !misalign ? NONE : op_is_store(op_q) ? ST_MISALIGN : LD_MISALIGN;

endmodule

//--- lsu_mem_stage.sv
// Memory stage: routes each op to the store queue, forwarding or the cache load port.
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_mem_stage
    import lsu_op_pkg::*;
    import lsu_resp_pkg::*;
(
    input  logic                  agu_valid_i,
    output logic                  agu_ready_o,
    input  lsu_op_e               agu_op_i,
    input  logic [`LSU_XLEN-1:0]  agu_addr_i,
    input  logic [`LSU_XLEN-1:0]  agu_data_i,
    input  logic [`LSU_ROB_W-1:0] agu_rob_tag_i,
    input  logic                  agu_exc_i,
    input  lsu_ecause_e           agu_cause_i,
    output logic                  sq_push_valid_o,
    input  logic                  sq_push_ready_i,
    output lsu_op_e               sq_op_o,
    output logic [`LSU_XLEN-1:0]  sq_addr_o,
    output logic [`LSU_XLEN-1:0]  sq_data_o,
    output lsu_op_e               fwd_op_o,
    output logic [`LSU_XLEN-1:0]  fwd_addr_o,
    input  logic                  fwd_hit_i,
    input  logic                  fwd_conflict_i,
    input  logic [`LSU_XLEN-1:0]  fwd_data_i,
    output logic                  ld_req_valid_o,
    input  logic                  ld_req_ready_i,
    output logic [`LSU_XLEN-1:0]  ld_req_addr_o,
    output logic                  pend_valid_o,
    input  logic                  pend_ready_i,
    output pend_kind_e            pend_kind_o,
    output logic [`LSU_ROB_W-1:0] pend_rob_tag_o,
    output lsu_op_e               pend_op_o,
    output logic [1:0]            pend_byte_off_o,
    output logic [`LSU_XLEN-1:0]  pend_data_o,
    output logic                  pend_exc_o,
    output lsu_ecause_e           pend_cause_o
);

    logic is_ld;
    logic to_sq;
    logic to_cache;
    logic blocked;

    assign to_sq    = !agu_exc_i && op_is_store(agu_op_i);
    assign is_ld    = !agu_exc_i && !op_is_store(agu_op_i);
    assign blocked  = is_ld && fwd_conflict_i;  // Held until the drain clears the overlap.
    assign to_cache = is_ld && !fwd_hit_i && !fwd_conflict_i;

    assign fwd_op_o   = agu_op_i;
    assign fwd_addr_o = agu_addr_i;

    // Each target sees valid only once the other targets can take the op too.
    assign sq_push_valid_o = agu_valid_i && to_sq && pend_ready_i;
    assign ld_req_valid_o  = agu_valid_i && to_cache && pend_ready_i;
    assign pend_valid_o    = agu_valid_i && !blocked && (!to_sq || sq_push_ready_i)
                             && (!to_cache || ld_req_ready_i);
    assign agu_ready_o     = pend_valid_o && pend_ready_i;

    assign sq_op_o       = agu_op_i;
    assign sq_addr_o     = agu_addr_i;
    assign sq_data_o     = agu_data_i;
    assign ld_req_addr_o = {agu_addr_i[`LSU_XLEN-1:2], 2'b00};

    assign pend_kind_o     = to_cache ? PEND_MEM : PEND_DONE;
    assign pend_rob_tag_o  = agu_rob_tag_i;
    assign pend_op_o       = agu_op_i;
    assign pend_byte_off_o = agu_addr_i[1:0];
    assign pend_data_o     = (is_ld && fwd_hit_i) ? fwd_data_i : '0;
    assign pend_exc_o      = agu_exc_i;
    assign pend_cause_o    = agu_cause_i;

endmodule

//--- lsu_store_queue.sv
// Circular store queue with byte enables, a load forwarding lookup and drain to the cache.
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_store_queue
    import lsu_op_pkg::*;
#(
    parameter int unsigned DEPTH = `LSU_SQ_DEPTH
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   push_valid_i,
    output logic                   push_ready_o,
    input  lsu_op_e                push_op_i,
    input  logic [`LSU_XLEN-1:0]   push_addr_i,
    input  logic [`LSU_XLEN-1:0]   push_data_i,
    input  lsu_op_e                fwd_op_i,
    input  logic [`LSU_XLEN-1:0]   fwd_addr_i,
    output logic                   fwd_hit_o,
    output logic                   fwd_conflict_o,
    output logic [`LSU_XLEN-1:0]   fwd_data_o,
    output logic                   st_valid_o,
    input  logic                   st_ready_i,
    output logic [`LSU_XLEN-1:0]   st_addr_o,
    output logic [`LSU_XLEN-1:0]   st_data_o,
    output logic [`LSU_XLEN/8-1:0] st_be_o
);

    localparam int unsigned AW = $clog2(DEPTH);

    logic [DEPTH-1:0]         valid_q;
    logic [AW-1:0]            wr_ptr_q;
    logic [AW-1:0]            rd_ptr_q;
    logic [`LSU_XLEN-1:0]     addr_q [DEPTH];
    logic [`LSU_XLEN-1:0]     data_q [DEPTH];
    logic [`LSU_XLEN/8-1:0]   be_q   [DEPTH];
    logic [`LSU_XLEN/8-1:0]   fwd_be;
    logic                     push_fire;
    logic                     st_fire;

    assign push_ready_o = !valid_q[wr_ptr_q];
    assign push_fire    = push_valid_i && push_ready_o;
    assign st_valid_o   = valid_q[rd_ptr_q];  // Drains as soon as a store is queued.
    assign st_fire      = st_valid_o && st_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q  <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_fire) begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q          <= wr_ptr_q + 1'b1;
            end
            if (st_fire) begin
                valid_q[rd_ptr_q] <= 1'b0;
                rd_ptr_q          <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_fire) begin
            addr_q[wr_ptr_q] <= {push_addr_i[`LSU_XLEN-1:2], 2'b00};
            data_q[wr_ptr_q] <= push_data_i << {push_addr_i[1:0], 3'b000};  // Lane aligned.
            be_q[wr_ptr_q]   <= op_be(push_op_i, push_addr_i[1:0]);
        end
    end

    assign fwd_be = op_be(fwd_op_i, fwd_addr_i[1:0]);

    // Walk oldest to youngest so the youngest overlapping entry decides.
    always_comb begin
        logic [AW-1:0] idx;
        logic          overlap;
        overlap    = 1'b0;
        fwd_hit_o  = 1'b0;
        fwd_data_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            idx = rd_ptr_q + AW'(i);
            if (valid_q[idx] && addr_q[idx][`LSU_XLEN-1:2] == fwd_addr_i[`LSU_XLEN-1:2]
                && |(be_q[idx] & fwd_be)) begin
                overlap    = 1'b1;
                fwd_hit_o  = (be_q[idx] & fwd_be) == fwd_be;
                fwd_data_o = data_q[idx];
            end
        end
        fwd_conflict_o = overlap && !fwd_hit_o;
    end

    assign st_addr_o = addr_q[rd_ptr_q];
    assign st_data_o = data_q[rd_ptr_q];
    assign st_be_o   = be_q[rd_ptr_q];

endmodule

//--- lsu_resp_stage.sv
// Response stage: in-order pending FIFO that captures load data and drives writeback.
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_resp_stage
    import lsu_op_pkg::*;
    import lsu_resp_pkg::*;
#(
    parameter int unsigned DEPTH = `LSU_PEND_DEPTH
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  pend_valid_i,
    output logic                  pend_ready_o,
    input  pend_kind_e            pend_kind_i,
    input  logic [`LSU_ROB_W-1:0] pend_rob_tag_i,
    input  lsu_op_e               pend_op_i,
    input  logic [1:0]            pend_byte_off_i,
    input  logic [`LSU_XLEN-1:0]  pend_data_i,
    input  logic                  pend_exc_i,
    input  lsu_ecause_e           pend_cause_i,
    input  logic                  ld_rsp_valid_i,
    output logic                  ld_rsp_ready_o,
    input  logic [`LSU_XLEN-1:0]  ld_rsp_data_i,
    input  logic                  ld_rsp_err_i,
    output logic                  wb_valid_o,
    input  logic                  wb_ready_i,
    output logic [`LSU_ROB_W-1:0] wb_rob_idx_o,
    output logic [`LSU_XLEN-1:0]  wb_data_o,
    output logic                  wb_exception_o,
    output lsu_ecause_e           wb_ecause_o
);

    localparam int unsigned AW = $clog2(DEPTH);
    localparam int unsigned CW = $clog2(DEPTH + 1);

    logic [AW-1:0]         wr_ptr_q;
    logic [AW-1:0]         rd_ptr_q;
    logic [CW-1:0]         count_q;
    pend_kind_e            kind_q  [DEPTH];
    logic [`LSU_ROB_W-1:0] tag_q   [DEPTH];
    lsu_op_e               op_q    [DEPTH];
    logic [1:0]            off_q   [DEPTH];
    logic [`LSU_XLEN-1:0]  data_q  [DEPTH];
    logic                  exc_q   [DEPTH];
    lsu_ecause_e           cause_q [DEPTH];
    logic                  head_valid;
    logic                  push_fire;
    logic                  pop_fire;
    logic [`LSU_XLEN-1:0]  ld_val;

    assign head_valid     = count_q != '0;
    assign pend_ready_o   = count_q != CW'(DEPTH);
    assign push_fire      = pend_valid_i && pend_ready_o;
    assign ld_rsp_ready_o = head_valid && kind_q[rd_ptr_q] == PEND_MEM;
    assign wb_valid_o     = head_valid && kind_q[rd_ptr_q] == PEND_DONE;
    assign pop_fire       = wb_valid_o && wb_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + AW'(push_fire);
            rd_ptr_q <= rd_ptr_q + AW'(pop_fire);
            count_q  <= count_q + CW'(push_fire) - CW'(pop_fire);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_fire) begin
            kind_q[wr_ptr_q]  <= pend_kind_i;
            tag_q[wr_ptr_q]   <= pend_rob_tag_i;
            op_q[wr_ptr_q]    <= pend_op_i;
            off_q[wr_ptr_q]   <= pend_byte_off_i;
            data_q[wr_ptr_q]  <= pend_data_i;
            exc_q[wr_ptr_q]   <= pend_exc_i;
            cause_q[wr_ptr_q] <= pend_cause_i;
        end
        if (ld_rsp_valid_i && ld_rsp_ready_o) begin  // Head entry, never the push slot.
            kind_q[rd_ptr_q] <= PEND_DONE;
            data_q[rd_ptr_q] <= ld_rsp_data_i;
            if (ld_rsp_err_i) begin
                exc_q[rd_ptr_q]   <= 1'b1;
                cause_q[rd_ptr_q] <= LD_FAULT;
            end
        end
    end

    always_comb begin
        logic [`LSU_XLEN-1:0] sh;
        sh = data_q[rd_ptr_q] >> {off_q[rd_ptr_q], 3'b000};
        case (op_q[rd_ptr_q])
            LB:      ld_val = {{(`LSU_XLEN-8){sh[7]}}, sh[7:0]};
            LH:      ld_val = {{(`LSU_XLEN-16){sh[15]}}, sh[15:0]};
            LW:      ld_val = sh;
            LBU:     ld_val = {{(`LSU_XLEN-8){1'b0}}, sh[7:0]};
            LHU:     ld_val = {{(`LSU_XLEN-16){1'b0}}, sh[15:0]};
            default: ld_val = '0;  // Stores write back zero.
        endcase
    end

    assign wb_rob_idx_o   = tag_q[rd_ptr_q];
    assign wb_data_o      = exc_q[rd_ptr_q] ? '0 : ld_val;
    assign wb_exception_o = exc_q[rd_ptr_q];
    assign wb_ecause_o    = cause_q[rd_ptr_q];

endmodule

//--- lsu_top.sv
// Load/store unit top: chains the AGU, memory stage and response stage around the store queue.
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top
    import lsu_op_pkg::*;
    import lsu_resp_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  lsu_op_e                req_op_i,
    input  logic [`LSU_XLEN-1:0]   req_base_i,
    input  logic [`LSU_XLEN-1:0]   req_offset_i,
    input  logic [`LSU_XLEN-1:0]   req_data_i,
    input  logic [`LSU_ROB_W-1:0]  req_rob_tag_i,
    output logic                   ld_req_valid_o,
    input  logic                   ld_req_ready_i,
    output logic [`LSU_XLEN-1:0]   ld_req_addr_o,
    input  logic                   ld_rsp_valid_i,
    output logic                   ld_rsp_ready_o,
    input  logic [`LSU_XLEN-1:0]   ld_rsp_data_i,
    input  logic                   ld_rsp_err_i,
    output logic                   st_valid_o,
    input  logic                   st_ready_i,
    output logic [`LSU_XLEN-1:0]   st_addr_o,
    output logic [`LSU_XLEN-1:0]   st_data_o,
    output logic [`LSU_XLEN/8-1:0] st_be_o,
    output logic                   wb_valid_o,
    input  logic                   wb_ready_i,
    output logic [`LSU_ROB_W-1:0]  wb_rob_idx_o,
    output logic [`LSU_XLEN-1:0]   wb_data_o,
    output logic                   wb_exception_o,
    output lsu_ecause_e            wb_ecause_o
);

    logic                  agu_valid, agu_ready, agu_exc;
    lsu_op_e               agu_op;
    logic [`LSU_XLEN-1:0]  agu_addr, agu_data;
    logic [`LSU_ROB_W-1:0] agu_rob_tag;
    lsu_ecause_e           agu_cause;

    logic                  sq_push_valid, sq_push_ready;
    lsu_op_e               sq_op, fwd_op;
    logic [`LSU_XLEN-1:0]  sq_addr, sq_data, fwd_addr, fwd_data;
    logic                  fwd_hit, fwd_conflict;

    logic                  pend_valid, pend_ready, pend_exc;
    pend_kind_e            pend_kind;
    logic [`LSU_ROB_W-1:0] pend_rob_tag;
    lsu_op_e               pend_op;
    logic [1:0]            pend_byte_off;
    logic [`LSU_XLEN-1:0]  pend_data;
    lsu_ecause_e           pend_cause;

    lsu_agu u_agu (
        .clk_i, .rst_n_i, .req_valid_i, .req_ready_o, .req_op_i, .req_base_i,
        .req_offset_i, .req_data_i, .req_rob_tag_i,
        .agu_valid_o(agu_valid), .agu_ready_i(agu_ready), .agu_op_o(agu_op),
        .agu_addr_o(agu_addr), .agu_data_o(agu_data), .agu_rob_tag_o(agu_rob_tag),
        .agu_exc_o(agu_exc), .agu_cause_o(agu_cause)
    );

    lsu_mem_stage u_mem (
        .agu_valid_i(agu_valid), .agu_ready_o(agu_ready), .agu_op_i(agu_op),
        .agu_addr_i(agu_addr), .agu_data_i(agu_data), .agu_rob_tag_i(agu_rob_tag),
        .agu_exc_i(agu_exc), .agu_cause_i(agu_cause),
        .sq_push_valid_o(sq_push_valid), .sq_push_ready_i(sq_push_ready),
        .sq_op_o(sq_op), .sq_addr_o(sq_addr), .sq_data_o(sq_data),
        .fwd_op_o(fwd_op), .fwd_addr_o(fwd_addr), .fwd_hit_i(fwd_hit),
        .fwd_conflict_i(fwd_conflict), .fwd_data_i(fwd_data),
        .ld_req_valid_o, .ld_req_ready_i, .ld_req_addr_o,
        .pend_valid_o(pend_valid), .pend_ready_i(pend_ready), .pend_kind_o(pend_kind),
        .pend_rob_tag_o(pend_rob_tag), .pend_op_o(pend_op), .pend_byte_off_o(pend_byte_off),
        .pend_data_o(pend_data), .pend_exc_o(pend_exc), .pend_cause_o(pend_cause)
    );

    lsu_store_queue #(.DEPTH(`LSU_SQ_DEPTH)) u_sq (
        .clk_i, .rst_n_i,
        .push_valid_i(sq_push_valid), .push_ready_o(sq_push_ready), .push_op_i(sq_op),
        .push_addr_i(sq_addr), .push_data_i(sq_data),
        .fwd_op_i(fwd_op), .fwd_addr_i(fwd_addr), .fwd_hit_o(fwd_hit),
        .fwd_conflict_o(fwd_conflict), .fwd_data_o(fwd_data),
        .st_valid_o, .st_ready_i, .st_addr_o, .st_data_o, .st_be_o
    );

    lsu_resp_stage #(.DEPTH(`LSU_PEND_DEPTH)) u_resp (
        .clk_i, .rst_n_i,
        .pend_valid_i(pend_valid), .pend_ready_o(pend_ready), .pend_kind_i(pend_kind),
        .pend_rob_tag_i(pend_rob_tag), .pend_op_i(pend_op), .pend_byte_off_i(pend_byte_off),
        .pend_data_i(pend_data), .pend_exc_i(pend_exc), .pend_cause_i(pend_cause),
        .ld_rsp_valid_i, .ld_rsp_ready_o, .ld_rsp_data_i, .ld_rsp_err_i,
        .wb_valid_o, .wb_ready_i, .wb_rob_idx_o, .wb_data_o, .wb_exception_o, .wb_ecause_o
    );

endmodule

//--- lsu_chk.sv
// Handshake assertions for the load/store unit, attached to lsu_top by bind.
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_chk
    import lsu_op_pkg::*;
    import lsu_resp_pkg::*;
(
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   req_valid_i,
    input logic                   req_ready_o,
    input lsu_op_e                req_op_i,
    input logic [`LSU_XLEN-1:0]   req_base_i,
    input logic [`LSU_XLEN-1:0]   req_offset_i,
    input logic [`LSU_XLEN-1:0]   req_data_i,
    input logic [`LSU_ROB_W-1:0]  req_rob_tag_i,
    input logic                   ld_req_valid_o,
    input logic                   ld_req_ready_i,
    input logic [`LSU_XLEN-1:0]   ld_req_addr_o,
    input logic                   st_valid_o,
    input logic                   st_ready_i,
    input logic [`LSU_XLEN-1:0]   st_addr_o,
    input logic [`LSU_XLEN-1:0]   st_data_o,
    input logic [`LSU_XLEN/8-1:0] st_be_o,
    input logic                   wb_valid_o,
    input logic                   wb_ready_i,
    input logic [`LSU_ROB_W-1:0]  wb_rob_idx_o,
    input logic [`LSU_XLEN-1:0]   wb_data_o,
    input logic                   wb_exception_o,
    input lsu_ecause_e            wb_ecause_o
);

    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i && !req_ready_o |=> req_valid_i
        && $stable({req_op_i, req_base_i, req_offset_i, req_data_i, req_rob_tag_i}))
        else $error("request payload changed under stall");

    a_ld_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ld_req_valid_o && !ld_req_ready_i |=> ld_req_valid_o && $stable(ld_req_addr_o))
        else $error("load request changed under stall");

    a_st_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        st_valid_o && !st_ready_i |=> st_valid_o && $stable({st_addr_o, st_data_o, st_be_o}))
        else $error("store drain changed under stall");

    a_wb_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o && !wb_ready_i |=> wb_valid_o
        && $stable({wb_rob_idx_o, wb_data_o, wb_exception_o, wb_ecause_o}))
        else $error("writeback changed under stall");

    a_wb_reset: assert property (@(posedge clk_i) !rst_n_i |-> !wb_valid_o)
        else $error("writeback valid during reset");

endmodule

bind lsu_top lsu_chk i_chk (.*);

//--- tb_clk_gen.sv
// Testbench clock and reset source: 20 ns clock, reset low for the first three cycles.
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        #2 rst_n_o = 1'b1;  // Released with the other inputs, after the edge.
    end

    always #10 clk_o = ~clk_o;

endmodule

//--- tb_lsu.sv
// Table-driven testbench for lsu_top with a byte memory model and random back-pressure.
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu
    import lsu_op_pkg::*;
    import lsu_resp_pkg::*;
;

    localparam int N_ROWS = 23;
    localparam int LIMIT  = 200;  // Cycles allowed per wait.
    localparam int QUIET  = 10;   // Idle cycles watched for stray writebacks.

    logic clk_i, rst_n_i;
    logic req_valid_i, req_ready_o;
    lsu_op_e req_op_i;
    logic [`LSU_XLEN-1:0] req_base_i, req_offset_i, req_data_i;
    logic [`LSU_ROB_W-1:0] req_rob_tag_i;
    logic ld_req_valid_o, ld_req_ready_i, ld_rsp_valid_i, ld_rsp_ready_o, ld_rsp_err_i;
    logic [`LSU_XLEN-1:0] ld_req_addr_o, ld_rsp_data_i, st_addr_o, st_data_o, wb_data_o;
    logic st_valid_o, st_ready_i, wb_valid_o, wb_ready_i, wb_exception_o;
    logic [`LSU_XLEN/8-1:0] st_be_o;
    logic [`LSU_ROB_W-1:0] wb_rob_idx_o;
    lsu_ecause_e wb_ecause_o;

    lsu_op_e              tbl_op   [N_ROWS];
    logic [`LSU_XLEN-1:0] tbl_base [N_ROWS];
    logic [`LSU_XLEN-1:0] tbl_off  [N_ROWS];
    logic [`LSU_XLEN-1:0] tbl_data [N_ROWS];
    logic [`LSU_XLEN-1:0] exp_data [N_ROWS];
    logic                 exp_exc  [N_ROWS];
    lsu_ecause_e          exp_cause[N_ROWS];
    logic [7:0] mem [256];      // Cache model, 64 words.
    logic [7:0] ref_mem [256];  // Reference view in program order.
    logic [`LSU_XLEN-1:0] rsp_data_q[$];
    logic rsp_err_q[$];
    int rsp_due_q[$];
    logic [31:0] lfsr_q = 32'hd0d53c5b;
    int n_rows = 0, wb_count = 0, cycle = 0;
    int data_errs = 0, tag_errs = 0, cause_errs = 0, other_errs = 0;
    logic timed_out = 1'b0;
    logic rsp_fire_q = 1'b0;

    tb_clk_gen u_clk (.clk_o(clk_i), .rst_n_o(rst_n_i));

    lsu_top i_dut (.*);

    task automatic take_bit(output logic b);
        b = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h80200003 : 32'h0);
    endtask

    task automatic add_row(lsu_op_e op, logic [31:0] base, logic [31:0] off, logic [31:0] d);
        tbl_op[n_rows]   = op;
        tbl_base[n_rows] = base;
        tbl_off[n_rows]  = off;
        tbl_data[n_rows] = d;
        n_rows++;
    endtask

    // Applies each row to the reference memory and records the expected writeback.
    task automatic build_expected();
        logic [31:0] a;
        logic [31:0] w;
        int size;
        logic mis;
        for (int i = 0; i < N_ROWS; i++) begin
            a    = tbl_base[i] + tbl_off[i];
            size = (tbl_op[i] inside {LB, LBU, SB}) ? 1 : (tbl_op[i] inside {LH, LHU, SH}) ? 2 : 4;
            mis  = (a % size) != 0;
            exp_data[i]  = '0;
            exp_exc[i]   = mis;
            exp_cause[i] = NONE;
            if (tbl_op[i] inside {SB, SH, SW}) begin
                if (mis) begin
                    exp_cause[i] = ST_MISALIGN;
                end else begin
                    for (int k = 0; k < size; k++) ref_mem[a + k] = tbl_data[i][8*k +: 8];
                end
            end else if (mis) begin
                exp_cause[i] = LD_MISALIGN;
            end else if (a >= 256) begin
                exp_exc[i]   = 1'b1;
                exp_cause[i] = LD_FAULT;
            end else begin
                w = {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
                case (tbl_op[i])
                    LB:      exp_data[i] = {{24{w[7]}}, w[7:0]};
                    LBU:     exp_data[i] = {24'h0, w[7:0]};
                    LH:      exp_data[i] = {{16{w[15]}}, w[15:0]};
                    LHU:     exp_data[i] = {16'h0, w[15:0]};
                    default: exp_data[i] = w;
                endcase
            end
        end
    endtask

    task automatic check_data(string name, logic [`LSU_XLEN-1:0] got, logic [`LSU_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_tag(logic [`LSU_ROB_W-1:0] got, logic [`LSU_ROB_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t wb_rob_idx_o got %0d exp %0d", $time, got, exp);
            tag_errs++;
        end
    endtask

    task automatic check_cause(logic got_exc, logic exp_exc_i, lsu_ecause_e got, lsu_ecause_e exp);
        if (got_exc !== exp_exc_i || got !== exp) begin
            $display("[FAIL] %0t wb_ecause_o got %0d/%s exp %0d/%s", $time,
                     got_exc, got.name(), exp_exc_i, exp.name());
            cause_errs++;
        end
    endtask

    // Handshakes are sampled mid-cycle, where every input and output is settled.
    always @(negedge clk_i) begin
        logic b0, b1;
        int d;
        rsp_fire_q = ld_rsp_valid_i && ld_rsp_ready_o;
        if (rst_n_i && st_valid_o && st_ready_i && st_addr_o < 256) begin
            for (int k = 0; k < 4; k++)
                if (st_be_o[k]) mem[st_addr_o + k] = st_data_o[8*k +: 8];
        end
        if (rst_n_i && ld_req_valid_o && ld_req_ready_i) begin
            take_bit(b0);
            take_bit(b1);
            d = {b1, b0};
            rsp_due_q.push_back(cycle + 2 + d % 3);
            rsp_err_q.push_back(ld_req_addr_o >= 256);
            rsp_data_q.push_back(ld_req_addr_o >= 256 ? 32'h0 : {mem[ld_req_addr_o + 3],
                mem[ld_req_addr_o + 2], mem[ld_req_addr_o + 1], mem[ld_req_addr_o]});
        end
        if (rst_n_i && wb_valid_o && wb_ready_i) begin
            if (wb_count >= N_ROWS) begin
                $display("Writeback seen after the last table row at %0t", $time);
                other_errs++;
            end else begin
                check_tag(wb_rob_idx_o, wb_count[`LSU_ROB_W-1:0]);
                check_data("wb_data_o", wb_data_o, exp_data[wb_count]);
                check_cause(wb_exception_o, exp_exc[wb_count], wb_ecause_o, exp_cause[wb_count]);
            end
            wb_count++;
        end
    end

    always @(posedge clk_i) begin
        cycle++;
        #2;
        take_bit(wb_ready_i);
        take_bit(ld_req_ready_i);
        take_bit(st_ready_i);
        if (rsp_fire_q) begin
            void'(rsp_data_q.pop_front());
            void'(rsp_err_q.pop_front());
            void'(rsp_due_q.pop_front());
            ld_rsp_valid_i = 1'b0;
        end
        if (!ld_rsp_valid_i && rsp_due_q.size() > 0 && cycle >= rsp_due_q[0]) begin
            ld_rsp_valid_i = 1'b1;  // Held until the DUT takes it.
            ld_rsp_data_i  = rsp_data_q[0];
            ld_rsp_err_i   = rsp_err_q[0];
        end
    end

    task automatic send_row(int i);
        int n;
        n = 0;
        @(posedge clk_i);
        #2;
        req_valid_i   = 1'b1;
        req_op_i      = tbl_op[i];
        req_base_i    = tbl_base[i];
        req_offset_i  = tbl_off[i];
        req_data_i    = tbl_data[i];
        req_rob_tag_i = i[`LSU_ROB_W-1:0];
        do begin
            @(negedge clk_i);
            n++;
        end while (!(req_valid_i && req_ready_o) && n < LIMIT);
        if (!(req_valid_i && req_ready_o)) begin
            $display("Request %0d was not accepted within %0d cycles", i, LIMIT);
            timed_out = 1'b1;
            other_errs++;
        end
    endtask

    initial begin
        int n;
        for (int a = 0; a < 256; a++) begin
            mem[a]     = 8'((a * 13) ^ (a >> 5) ^ 8'h5a);
            ref_mem[a] = mem[a];
        end
        {req_valid_i, ld_rsp_valid_i, ld_rsp_err_i} = '0;
        {ld_req_ready_i, st_ready_i, wb_ready_i} = '0;
        req_op_i = LB;
        {req_base_i, req_offset_i, req_data_i, ld_rsp_data_i} = '0;
        req_rob_tag_i = '0;
        add_row(SW,  32'h20, 32'h0, 32'h80f17f9c);
        add_row(LW,  32'h20, 32'h0, 32'h0);
        add_row(LB,  32'h1c, 32'h4, 32'h0);
        add_row(LBU, 32'h20, 32'h1, 32'h0);
        add_row(LH,  32'h20, 32'h2, 32'h0);
        add_row(LHU, 32'h22, 32'h0, 32'h0);
        add_row(SB,  32'h20, 32'h5, 32'h000000a5);
        add_row(SH,  32'h20, 32'h6, 32'h00001234);
        add_row(LW,  32'h24, 32'h0, 32'h0);       // Wider than the queued stores.
        add_row(SH,  32'h30, 32'h0, 32'h0000beef);
        add_row(LH,  32'h30, 32'h0, 32'h0);
        add_row(LW,  32'h30, 32'h1, 32'h0);
        add_row(SW,  32'h40, 32'h2, 32'hdeadbeef);
        add_row(SH,  32'h40, 32'h1, 32'h0000cafe);
        add_row(LW,  32'h40, 32'h0, 32'h0);
        add_row(LH,  32'h41, 32'h0, 32'h0);
        add_row(LW,  32'h80, 32'h80, 32'h0);      // Word 64, faults.
        add_row(LBU, 32'h3f, 32'h0, 32'h0);
        add_row(SB,  32'h3c, 32'h0, 32'h0000007e);
        add_row(LB,  32'h3c, 32'h0, 32'h0);
        add_row(LW,  32'h10, 32'h10, 32'h0);
        add_row(LHU, 32'h26, 32'h0, 32'h0);
        add_row(LB,  32'hff, 32'h0, 32'h0);
        build_expected();
        n = 0;
        while (!rst_n_i && n < LIMIT) begin
            @(posedge clk_i);
            n++;
        end
        if (!rst_n_i) begin
            $display("Reset was not released within %0d cycles", LIMIT);
            timed_out = 1'b1;
            other_errs++;
        end
        for (int i = 0; i < N_ROWS; i++) begin
            if (!timed_out) send_row(i);
        end
        @(posedge clk_i);
        #2 req_valid_i = 1'b0;
        n = 0;
        while (!timed_out && wb_count < N_ROWS && n < LIMIT) begin
            @(posedge clk_i);
            n++;
        end
        if (!timed_out && wb_count < N_ROWS) begin
            $display("Only %0d of %0d writebacks arrived", wb_count, N_ROWS);
            other_errs++;
        end
        // A stray writeback after the last row shows up here.
        n = 0;
        while (!timed_out && n < QUIET) begin
            @(posedge clk_i);
            n++;
        end
        $display("Errors: data %0d, tag %0d, cause %0d, other %0d",
                 data_errs, tag_errs, cause_errs, other_errs);
        if (data_errs + tag_errs + cause_errs + other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
lsu_op_pkg.sv
lsu_resp_pkg.sv
lsu_agu.sv
lsu_mem_stage.sv
lsu_store_queue.sv
lsu_resp_stage.sv
lsu_top.sv
lsu_chk.sv
tb_clk_gen.sv
tb_lsu.sv

//--- Makefile
# Verilator build and run of the load/store unit testbench.
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_lsu, check $(LOG) for the pass message"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu \
		-Mdir obj_dir -f filelist.f
	./obj_dir/Vtb_lsu > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
